//--- corebus_settings.svh
//==================================================
// Sizes shared by the corebus slave cluster
// CB_TARGETS and CB_BANK_WORDS must be powers of two
//==================================================
`ifndef COREBUS_SETTINGS_SVH
`define COREBUS_SETTINGS_SVH

`define CB_ADDR_W      16  // Request address width
`define CB_DATA_W      32  // One data word per request
`define CB_ID_W        4   // Request id width

// Bank index sits in the top address bits, word offset in the low bits
`define CB_TARGETS     4
`define CB_BANK_WORDS  16

`define CB_FIFO_DEPTH  4   // Entries per FIFO

`endif

//--- corebus_pkg.sv
//==================================================
// Command and response types of the corebus cluster
//==================================================
`default_nettype none

`include "corebus_settings.svh"

package corebus_pkg;

  // bit[2] marks broadcast, bit[1] marks write, bit[0] marks non-posted
  typedef enum logic [2:0] {
    CB_READ                 = 3'b001,
    CB_WRITE                = 3'b010,
    CB_WRITE_NON_POSTED     = 3'b011,
    CB_BROADCAST            = 3'b110,
    CB_BROADCAST_NON_POSTED = 3'b111
  } corebus_command_type;

  typedef enum logic {
    CB_RESP_READ  = 1'b0,  // Carries data
    CB_RESP_WRITE = 1'b1   // Acknowledge only
  } corebus_response_type;

  // FIFO payloads inside the top level
  typedef struct packed {
    corebus_command_type    cmd;
    logic [`CB_ID_W-1:0]    id;
    logic [`CB_ADDR_W-1:0]  addr;
    logic [`CB_DATA_W-1:0]  data;
  } corebus_request;

  typedef struct packed {
    corebus_response_type   resp;
    logic [`CB_ID_W-1:0]    id;
    logic [`CB_DATA_W-1:0]  data;
  } corebus_response;

endpackage

`default_nettype wire

//--- corebus_broadcast_forcer.sv
//==================================================
// Purely combinational, adds no cycle to the path
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "corebus_settings.svh"

module corebus_broadcast_forcer
  import corebus_pkg::*;
#(
  parameter bit ENABLE_BROADCAST_NON_POSTED = 1'b0
)(
  input  var logic                   condition,
  // Upstream side
  input  var logic                   in_valid,
  input  var corebus_command_type    in_cmd,
  input  var logic [`CB_ID_W-1:0]    in_id,
  input  var logic [`CB_ADDR_W-1:0]  in_addr,
  input  var logic [`CB_DATA_W-1:0]  in_data,
  output var logic                   in_ready,
  // Downstream side
  output var logic                   out_valid,
  output var corebus_command_type    out_cmd,
  output var logic [`CB_ID_W-1:0]    out_id,
  output var logic [`CB_ADDR_W-1:0]  out_addr,
  output var logic [`CB_DATA_W-1:0]  out_data,
  input  var logic                   out_ready
);

  function automatic corebus_command_type get_cmd(
    corebus_command_type cmd,
    logic                force_broadcast
  );
    logic to_bc;
    logic to_bc_np;

    to_bc    = (cmd == CB_WRITE) && force_broadcast;
    to_bc_np = (cmd == CB_WRITE_NON_POSTED) && force_broadcast &&
               ENABLE_BROADCAST_NON_POSTED;
    if (to_bc) begin
      return CB_BROADCAST;
    end else if (to_bc_np) begin
      return CB_BROADCAST_NON_POSTED;
    end
    return cmd;  // Reads and all others unchanged
  endfunction

  always_comb begin
    in_ready  = out_ready;  // Ready flows backwards untouched
    out_valid = in_valid;
    out_cmd   = get_cmd(in_cmd, condition);
    out_id    = in_id;
    out_addr  = in_addr;
    out_data  = in_data;
  end

endmodule

`default_nettype wire

//--- corebus_fifo.sv
//==================================================
// Full FIFO still accepts a push when popped that cycle
// so push_ready depends on pop_ready combinationally
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "corebus_settings.svh"

module corebus_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `CB_FIFO_DEPTH
)(
  input  var logic     clk,
  input  var logic     rst_n,
  input  var logic     push_valid,
  input  var payload_t push_data,
  output var logic     push_ready,
  output var logic     pop_valid,
  output var payload_t pop_data,
  input  var logic     pop_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;  // Wrap for any depth
    end
    return ptr + 1'b1;
  endfunction

  assign full       = (count == CNT_W'(DEPTH));
  assign empty      = (count == '0);
  assign push_ready = !full || pop_ready;
  assign pop_valid  = !empty;
  assign pop_data   = mem[rd_ptr];
  assign push       = push_valid && push_ready;
  assign pop        = pop_valid && pop_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or both at once
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- corebus_target_array.sv
//==================================================
// Address bits between bank index and word offset are ignored
// Only reads and non-posted commands produce a response
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "corebus_settings.svh"

module corebus_target_array
  import corebus_pkg::*;
(
  input  var logic                   clk,
  input  var logic                   rst_n,
  // Request side
  input  var logic                   req_valid,
  input  var corebus_command_type    req_cmd,
  input  var logic [`CB_ID_W-1:0]    req_id,
  input  var logic [`CB_ADDR_W-1:0]  req_addr,
  input  var logic [`CB_DATA_W-1:0]  req_data,
  output var logic                   req_ready,
  // Response side
  output var logic                   rsp_valid,
  output var corebus_response_type   rsp_type,
  output var logic [`CB_ID_W-1:0]    rsp_id,
  output var logic [`CB_DATA_W-1:0]  rsp_data,
  input  var logic                   rsp_ready
);

  localparam int BANK_W = $clog2(`CB_TARGETS);
  localparam int OFFS_W = $clog2(`CB_BANK_WORDS);

  logic [`CB_DATA_W-1:0] bank [`CB_TARGETS][`CB_BANK_WORDS];
  logic [BANK_W-1:0]     sel;
  logic [OFFS_W-1:0]     offs;
  logic                  accept;
  logic                  needs_rsp;
  logic                  is_read;

  assign sel    = req_addr[`CB_ADDR_W-1 -: BANK_W];  // Top bits pick the bank
  assign offs   = req_addr[OFFS_W-1:0];
  assign accept = req_valid && req_ready;

  // One condition gates both sides, response space is always checked
  assign req_ready = rsp_ready;

  always_comb begin
    is_read   = (req_cmd == CB_READ);
    needs_rsp = is_read ||
                (req_cmd == CB_WRITE_NON_POSTED) ||
                (req_cmd == CB_BROADCAST_NON_POSTED);
  end

  always_comb begin
    rsp_valid = req_valid && needs_rsp;
    rsp_type  = is_read ? CB_RESP_READ : CB_RESP_WRITE;
    rsp_id    = req_id;
    rsp_data  = is_read ? bank[sel][offs] : '0;  // Read sees the pre-edge word
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int t = 0; t < `CB_TARGETS; t++) begin
        for (int w = 0; w < `CB_BANK_WORDS; w++) begin
          bank[t][w] <= '0;
        end
      end
    end else if (accept) begin
      case (req_cmd)
        CB_WRITE,
        CB_WRITE_NON_POSTED: begin
          bank[sel][offs] <= req_data;
        end
        CB_BROADCAST,
        CB_BROADCAST_NON_POSTED: begin
          // Same offset in every bank
          for (int t = 0; t < `CB_TARGETS; t++) begin
            bank[t][offs] <= req_data;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- corebus_subsys.sv
//==================================================
// Responses leave in request order, latency of 2 or more
// resp_ready reaches cmd_ready through a combinational path
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "corebus_settings.svh"

module corebus_subsys
  import corebus_pkg::*;
#(
  parameter bit ENABLE_BROADCAST_NON_POSTED = 1'b0
)(
  input  var logic                   clk,
  input  var logic                   rst_n,
  input  var logic                   condition,
  // Request channel
  input  var logic                   cmd_valid,
  input  var corebus_command_type    cmd,
  input  var logic [`CB_ID_W-1:0]    cmd_id,
  input  var logic [`CB_ADDR_W-1:0]  cmd_addr,
  input  var logic [`CB_DATA_W-1:0]  cmd_data,
  output var logic                   cmd_ready,
  // Response channel
  output var logic                   resp_valid,
  output var corebus_response_type   resp,
  output var logic [`CB_ID_W-1:0]    resp_id,
  output var logic [`CB_DATA_W-1:0]  resp_data,
  input  var logic                   resp_ready
);

  // Forcer to command FIFO
  logic            fwd_valid;
  logic            fwd_ready;
  corebus_request  fwd_req;
  // Command FIFO to target array
  logic            exe_valid;
  logic            exe_ready;
  corebus_request  exe_req;
  // Target array to response FIFO
  logic            rsp_push_valid;
  logic            rsp_push_ready;
  corebus_response rsp_push;
  corebus_response rsp_pop;

  corebus_broadcast_forcer #(
    .ENABLE_BROADCAST_NON_POSTED (ENABLE_BROADCAST_NON_POSTED)
  ) i_forcer (
    .condition (condition),
    .in_valid  (cmd_valid),
    .in_cmd    (cmd),
    .in_id     (cmd_id),
    .in_addr   (cmd_addr),
    .in_data   (cmd_data),
    .in_ready  (cmd_ready),
    .out_valid (fwd_valid),
    .out_cmd   (fwd_req.cmd),
    .out_id    (fwd_req.id),
    .out_addr  (fwd_req.addr),
    .out_data  (fwd_req.data),
    .out_ready (fwd_ready)
  );

  corebus_fifo #(
    .payload_t (corebus_request),
    .DEPTH     (`CB_FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (fwd_valid),
    .push_data  (fwd_req),
    .push_ready (fwd_ready),
    .pop_valid  (exe_valid),
    .pop_data   (exe_req),
    .pop_ready  (exe_ready)
  );

  corebus_target_array i_target_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (exe_valid),
    .req_cmd   (exe_req.cmd),
    .req_id    (exe_req.id),
    .req_addr  (exe_req.addr),
    .req_data  (exe_req.data),
    .req_ready (exe_ready),
    .rsp_valid (rsp_push_valid),
    .rsp_type  (rsp_push.resp),
    .rsp_id    (rsp_push.id),
    .rsp_data  (rsp_push.data),
    .rsp_ready (rsp_push_ready)
  );

  corebus_fifo #(
    .payload_t (corebus_response),
    .DEPTH     (`CB_FIFO_DEPTH)
  ) i_rsp_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (rsp_push_valid),
    .push_data  (rsp_push),
    .push_ready (rsp_push_ready),
    .pop_valid  (resp_valid),
    .pop_data   (rsp_pop),
    .pop_ready  (resp_ready)
  );

  // Unpack the response payload onto the loose ports
  assign resp      = rsp_pop.resp;
  assign resp_id   = rsp_pop.id;
  assign resp_data = rsp_pop.data;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
//==================================================
// Free-running clock, starts low at time zero
//==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
)(
  output var logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // Half period per phase
  end

endmodule

`default_nettype wire

//--- corebus_checker.sv
//==================================================
// FIFO protocol assertions, bound into every corebus_fifo
//==================================================
`timescale 1ns/1ps
`default_nettype none

module corebus_checker #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 4
)(
  input var logic              clk,
  input var logic              rst_n,
  input var logic              push_valid,
  input var logic              push_ready,
  input var logic              pop_valid,
  input var logic              pop_ready,
  input var logic [DATA_W-1:0] pop_data
);

  logic pushed;
  logic popped;
  int   level;  // Items held, counted from the handshakes alone

  assign pushed = push_valid && push_ready;
  assign popped = pop_valid && pop_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= 0;
    end else begin
      level <= level + (pushed ? 1 : 0) - (popped ? 1 : 0);
    end
  end

  // A full FIFO only takes a push when the head leaves at the same edge
  push_while_full: assert property (@(posedge clk) disable iff (!rst_n)
    (pushed && level == DEPTH) |-> popped)
    else $error("FIFO accepted a push while full");

  pop_while_empty: assert property (@(posedge clk) disable iff (!rst_n)
    popped |-> (level != 0))
    else $error("FIFO gave a pop while empty");

  pop_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)))
    else $error("FIFO head changed while the consumer stalled");

endmodule

bind corebus_fifo corebus_checker #(
  .DATA_W ($bits(payload_t)),
  .DEPTH  (DEPTH)
) i_checker (
  .clk        (clk),
  .rst_n      (rst_n),
  .push_valid (push_valid),
  .push_ready (push_ready),
  .pop_valid  (pop_valid),
  .pop_ready  (pop_ready),
  .pop_data   (pop_data)
);

`default_nettype wire

//--- corebus_tb.sv
//==================================================
// Runs with ENABLE_BROADCAST_NON_POSTED set to 1
// Model banks update at request accept, responses kept in order
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "corebus_settings.svh"

module corebus_tb
  import corebus_pkg::*;
;

  localparam bit          BC_NP         = 1'b1;
  localparam int          CLK_PERIOD    = 20;
  localparam int          RESET_CYCLES  = 16;
  localparam int          DIRECTED_REQS = 23;
  localparam int          NUM_RANDOM    = 400;
  localparam int          WATCHDOG_NS   =
    ((DIRECTED_REQS + NUM_RANDOM) * 40 + RESET_CYCLES) * CLK_PERIOD;
  localparam logic [31:0] SEED          = 32'h8afc7a2b;
  localparam int          BANK_W        = $clog2(`CB_TARGETS);
  localparam int          OFFS_W        = $clog2(`CB_BANK_WORDS);

  logic                   clk;
  logic                   rst_n;
  logic                   condition;
  logic                   cmd_valid;
  corebus_command_type    cmd;
  logic [`CB_ID_W-1:0]    cmd_id;
  logic [`CB_ADDR_W-1:0]  cmd_addr;
  logic [`CB_DATA_W-1:0]  cmd_data;
  logic                   cmd_ready;
  logic                   resp_valid;
  corebus_response_type   resp;
  logic [`CB_ID_W-1:0]    resp_id;
  logic [`CB_DATA_W-1:0]  resp_data;
  logic                   resp_ready;

  logic [`CB_DATA_W-1:0]  model_bank [`CB_TARGETS][`CB_BANK_WORDS];
  corebus_response        exp_q [$];
  string                  name_q [$];
  logic [`CB_ID_W-1:0]    id_ctr;
  logic [31:0]            req_state;
  logic [31:0]            rdy_state;
  logic                   backpressure;
  int                     errors;
  int                     n_resp;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) i_clk (.clk(clk));

  corebus_subsys #(
    .ENABLE_BROADCAST_NON_POSTED (BC_NP)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .condition  (condition),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_id     (cmd_id),
    .cmd_addr   (cmd_addr),
    .cmd_data   (cmd_data),
    .cmd_ready  (cmd_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_id    (resp_id),
    .resp_data  (resp_data),
    .resp_ready (resp_ready)
  );

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Command after the broadcast rewrite
  function automatic corebus_command_type forced_cmd(corebus_command_type c, logic cond);
    if (cond && c == CB_WRITE) begin
      return CB_BROADCAST;
    end
    if (cond && BC_NP && c == CB_WRITE_NON_POSTED) begin
      return CB_BROADCAST_NON_POSTED;
    end
    return c;
  endfunction

  function automatic corebus_command_type pick_cmd(logic [2:0] sel);
    case (sel)
      3'd0, 3'd1: return CB_READ;
      3'd4:       return CB_WRITE_NON_POSTED;
      3'd5:       return CB_BROADCAST;
      3'd6:       return CB_BROADCAST_NON_POSTED;
      default:    return CB_WRITE;
    endcase
  endfunction

  function automatic logic [`CB_ADDR_W-1:0] make_addr(logic [BANK_W-1:0] b,
                                                      logic [OFFS_W-1:0] o);
    return {b, {(`CB_ADDR_W-BANK_W-OFFS_W){1'b0}}, o};
  endfunction

  task automatic check_type(input string name, input corebus_response_type exp_t,
                            input corebus_response_type act_t);
    if (act_t !== exp_t) begin
      errors++;
      $display("error %s: expected %s actual %s", name, exp_t.name(), act_t.name());
    end
  endtask

  task automatic check_id_data(input string name,
                               input logic [`CB_ID_W-1:0] exp_id,
                               input logic [`CB_ID_W-1:0] act_id,
                               input logic [`CB_DATA_W-1:0] exp_d,
                               input logic [`CB_DATA_W-1:0] act_d);
    if (act_id !== exp_id || act_d !== exp_d) begin
      errors++;
      $display("error %s: expected id %0h data %08h actual id %0h data %08h",
               name, exp_id, exp_d, act_id, act_d);
    end
  endtask

  // Apply an accepted request to the model banks and queue its response
  task automatic model_accept(input string name, input corebus_command_type c,
                              input logic [`CB_ID_W-1:0] id,
                              input logic [`CB_ADDR_W-1:0] addr,
                              input logic [`CB_DATA_W-1:0] data, input logic cond);
    corebus_command_type eff;
    corebus_response     expected;
    logic [BANK_W-1:0]   b;
    logic [OFFS_W-1:0]   o;

    eff           = forced_cmd(c, cond);
    b             = addr[`CB_ADDR_W-1 -: BANK_W];
    o             = addr[OFFS_W-1:0];
    expected.resp = CB_RESP_WRITE;
    expected.id   = id;
    expected.data = '0;
    if (eff == CB_READ) begin
      expected.resp = CB_RESP_READ;
      expected.data = model_bank[b][o];
    end else if (eff == CB_WRITE || eff == CB_WRITE_NON_POSTED) begin
      model_bank[b][o] = data;
    end else begin
      for (int t = 0; t < `CB_TARGETS; t++) begin
        model_bank[t][o] = data;
      end
    end
    if (eff == CB_READ || eff == CB_WRITE_NON_POSTED || eff == CB_BROADCAST_NON_POSTED) begin
      exp_q.push_back(expected);
      name_q.push_back(name);
    end
  endtask

  // Holds the request until the edge that accepts it, returns 2 ns before the next edge
  task automatic send_req(input string name, input corebus_command_type c,
                          input logic [`CB_ADDR_W-1:0] addr,
                          input logic [`CB_DATA_W-1:0] data, input logic cond);
    logic done;

    done = 1'b0;
    @(posedge clk);
    #2;
    cmd_valid = 1'b1;
    cmd       = c;
    cmd_id    = id_ctr;
    cmd_addr  = addr;
    cmd_data  = data;
    condition = cond;
    while (!done) begin
      #16;
      done = cmd_ready;
      if (!done) begin
        @(posedge clk);
        #2;
      end
    end
    model_accept(name, c, id_ctr, addr, data, cond);
    id_ctr = id_ctr + 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic print_summary();
    $display("Summary: %0d errors, %0d responses checked", errors, n_resp);
  endtask

  initial begin : main_flow
    logic [31:0] d;

    rst_n        = 1'b0;
    condition    = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = CB_READ;
    cmd_id       = '0;
    cmd_addr     = '0;
    cmd_data     = '0;
    resp_ready   = 1'b0;
    backpressure = 1'b0;
    id_ctr       = '0;
    errors       = 0;
    n_resp       = 0;
    req_state    = SEED;
    rdy_state    = ~SEED;  // Separate stream for resp_ready
    for (int t = 0; t < `CB_TARGETS; t++) begin
      for (int w = 0; w < `CB_BANK_WORDS; w++) begin
        model_bank[t][w] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #16;
    if (!cmd_ready || resp_valid) begin
      errors++;
      $display("After reset cmd_ready should be high and resp_valid low");
    end

    send_req("unicast_write_read", CB_WRITE, make_addr(2'd1, 4'd3), 32'hcafe_0001, 1'b0);
    send_req("unicast_write_read", CB_READ, make_addr(2'd1, 4'd3), 32'h0, 1'b0);
    send_req("posted_broadcast", CB_WRITE, make_addr(2'd0, 4'd7), 32'hb0b0_0007, 1'b1);
    for (int b = 0; b < `CB_TARGETS; b++) begin
      send_req("posted_broadcast", CB_READ, make_addr(BANK_W'(b), 4'd7), 32'h0, 1'b0);
    end
    send_req("np_broadcast", CB_WRITE_NON_POSTED, make_addr(2'd3, 4'd9), 32'h5a5a_0009, 1'b1);
    for (int b = 0; b < `CB_TARGETS; b++) begin
      send_req("np_broadcast", CB_READ, make_addr(BANK_W'(b), 4'd9), 32'h0, 1'b0);
    end
    send_req("np_unicast", CB_WRITE_NON_POSTED, make_addr(2'd2, 4'd9), 32'h1111_2222, 1'b0);
    for (int b = 0; b < `CB_TARGETS; b++) begin
      send_req("np_unicast", CB_READ, make_addr(BANK_W'(b), 4'd9), 32'h0, 1'b0);
    end
    for (int b = 0; b < `CB_TARGETS; b++) begin
      send_req("read_not_broadcast", CB_WRITE, make_addr(BANK_W'(b), 4'd5),
               32'h4000_0000 + b, 1'b0);
    end
    send_req("read_not_broadcast", CB_READ, make_addr(2'd2, 4'd5), 32'h0, 1'b1);
    send_req("read_not_broadcast", CB_READ, make_addr(2'd1, 4'd5), 32'h0, 1'b0);

    backpressure = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      req_state = xorshift(req_state);
      d         = xorshift(req_state ^ 32'h0000_ffff);
      if (req_state[31:29] == 3'd0) begin
        idle_cycle();  // Occasional gap in the request stream
      end
      send_req("random_mix", pick_cmd(req_state[26:24]), req_state[15:0], d, req_state[16]);
    end
    backpressure = 1'b0;
    idle_cycle();

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // Stray responses would show up here
    print_summary();
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : take_responses
    corebus_response expected;
    string           name;

    wait (rst_n);
    forever begin
      @(posedge clk);
      #2;
      rdy_state  = xorshift(rdy_state);
      resp_ready = backpressure ? (rdy_state[2:0] >= 3'd5) : 1'b1;
      #16;
      if (resp_ready && !cmd_ready) begin
        errors++;
        $display("cmd_ready dropped at %0t while responses were being taken", $time);
      end
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Response with id %0h arrived at %0t with none expected", resp_id, $time);
        end else begin
          expected = exp_q.pop_front();
          name     = name_q.pop_front();
          check_type(name, expected.resp, resp);
          check_id_data(name, expected.id, resp_id, expected.data, resp_data);
          n_resp++;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    errors++;
    $display("Timeout after %0d ns with %0d responses still expected", WATCHDOG_NS,
             exp_q.size());
    print_summary();
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
corebus_pkg.sv
corebus_broadcast_forcer.sv
corebus_fifo.sv
corebus_target_array.sv
corebus_subsys.sv
tb_clock_gen.sv
corebus_checker.sv
corebus_tb.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := corebus_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A crashed or aborted run counts as a failure too
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
